// File: cpu_trace.txt
# L address word = preload, R = run to halt, E register value = expected contents
# N count = expected instructionDone pulses, all numbers in hex
L 000 08800005
L 001 0907FFFD
L 002 01800040
L 003 0208003C
L 004 1A890000
L 005 23108000
L 006 2B9A0000
L 007 341A0000
L 008 3C90000A
L 009 14000050
L 00A 0508004B
L 00B 3D87FFFF
L 00C 40000000
L 040 12345678
L 041 A5A55A5A
L 050 13579BDF
R
E 0 00000000
E 1 00000005
E 2 FFFFFFFD
E 3 12345678
E 4 A5A55A5A
E 5 00000002
E 6 FFFFFFF8
E 7 00245258
E 8 B7B55E7A
E 9 00000007
E A B7B55E7A
E B FFFFFFFF
E C 00000000
N C

// File: all.f
+incdir+.
cpuTypes_pkg.sv
controlSequencer.sv
registerFile.sv
aluUnit.sv
memoryInterface.sv
cpuTop.sv
cpuTop_checker.sv
cpuTop_tb.sv

// File: run.sh
#!/bin/bash
# Build and run the CPU testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module cpuTop_tb -f all.f -o simv
if [ $? -ne 0 ]; then
    echo "Verilator compile step did not succeed"
    exit 1
fi

./obj_dir/simv > sim.log 2>&1
simStatus=$?
cat sim.log

if grep -q "Regression failed" sim.log; then
    exit 1
fi
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi
exit 0

// File: cpuTop_tb.sv
`timescale 1ns/100ps
`include "cpu_params.svh"

module cpuTop_tb;

    logic                              clock = 1'b0;
    logic                              reset;
    logic                              run;
    logic                              loadEnable;
    logic [`CPU_ADDR_WIDTH-1:0]        loadAddress;
    logic [`CPU_WIDTH-1:0]             loadData;
    logic [$clog2(`CPU_REG_COUNT)-1:0] debugSelect;
    logic [`CPU_WIDTH-1:0]             debugValue;
    logic                              halted;
    logic                              instructionDone;

    int doneCount = 0;    // Retired instructions
    int checkCount = 0;

    cpuTop uut (
        .clock(clock), .reset(reset), .run(run), .loadEnable(loadEnable),
        .loadAddress(loadAddress), .loadData(loadData), .debugSelect(debugSelect),
        .debugValue(debugValue), .halted(halted), .instructionDone(instructionDone)
    );

    bind cpuTop cpuTop_checker assertions (
        .clock(clock), .reset(reset), .pcOut(pcOut), .zOut(zOut), .mdrOut(mdrOut),
        .regOut(regOut), .cOut(cOut), .baOut(baOut), .marIn(marIn),
        .memWrite(memWrite), .halted(halted), .instructionDone(instructionDone)
    );

    always #10 clock = ~clock;  // 20 ns period

    always @(posedge clock) begin
        if (reset) begin
            doneCount <= 0;
        end else if (instructionDone) begin
            doneCount <= doneCount + 1;
        end
    end

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("Regression failed");
        $fatal(1, "%s", reason);
    endtask

    task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
                              input string what);
        checkCount++;
        if (actual !== expected) begin
            $display("FAILED at %0d ns: %s, got %h, expected %h", $time, what, actual,
                     expected);
            $display("Regression failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic preloadWord(input logic [31:0] address, input logic [31:0] word);
        @(negedge clock);
        loadEnable  = 1'b1;
        loadAddress = address[`CPU_ADDR_WIDTH-1:0];
        loadData    = word;
        @(negedge clock);
        loadEnable  = 1'b0;
    endtask

    // Debug port is combinational and settles before the sample
    task automatic readRegister(input logic [31:0] index, output logic [31:0] value);
        @(negedge clock);
        debugSelect = index[$clog2(`CPU_REG_COUNT)-1:0];
        #5;
        value = debugValue;
    endtask

    task automatic checkIdleState();
        logic [31:0] value;
        for (int r = 0; r < `CPU_REG_COUNT; r++) begin
            readRegister(r, value);
            checkValue(value, '0, $sformatf("R%0d before run", r));
        end
        checkValue(32'(halted), '0, "halted before run");
    endtask

    task automatic runUntilHalt();
        int cycles;
        @(negedge clock);
        run = 1'b1;
        @(negedge clock);
        run = 1'b0;
        cycles = 0;
        while (!halted && cycles < 2000) begin
            @(negedge clock);
            cycles++;
        end
        if (!halted) begin
            abortRun("Timeout: the processor never halted within 2000 cycles");
        end
    endtask

    initial begin
        int          traceFile;
        string       line;
        logic [7:0]  kind;
        logic [31:0] first;
        logic [31:0] second;
        logic [31:0] value;
        reset       = 1'b1;
        run         = 1'b0;
        loadEnable  = 1'b0;
        loadAddress = '0;
        loadData    = '0;
        debugSelect = '0;
        repeat (16) @(negedge clock);
        reset = 1'b0;
        traceFile = $fopen("cpu_trace.txt", "r");
        if (traceFile == 0) begin
            abortRun("Could not open cpu_trace.txt for reading");
        end
        while ($fgets(line, traceFile) != 0) begin
            kind = 8'h00;
            void'($sscanf(line, "%c %h %h", kind, first, second));
            case (kind)
                "L": preloadWord(first, second);
                "R": begin
                    checkIdleState();
                    runUntilHalt();
                end
                "E": begin
                    readRegister(first, value);
                    checkValue(value, second, $sformatf("R%0d after halt", first));
                end
                "N": begin
                    checkValue(32'(doneCount), first, "instructionDone count");
                    checkValue(32'(halted), 32'd1, "halted after the run");
                end
                default: ;  // Comment or blank line
            endcase
        end
        $fclose(traceFile);
        if (checkCount == 0) begin
            abortRun("The trace file held no checks");
        end else begin
            $display("Regression passed");
            $finish;
        end
    end

endmodule

// File: cpuTop_checker.sv
`timescale 1ns/100ps

module cpuTop_checker (
    input logic clock,
    input logic reset,
    input logic pcOut,
    input logic zOut,
    input logic mdrOut,
    input logic regOut,
    input logic cOut,
    input logic baOut,
    input logic marIn,
    input logic memWrite,
    input logic halted,
    input logic instructionDone
);

    // The bus has a single driver per step
    busSourceOneHot: assert property (@(posedge clock) disable iff (reset)
        $onehot0({pcOut, zOut, mdrOut, regOut, cOut, baOut}))
        else $error("more than one bus source is active");

    marWriteApart: assert property (@(posedge clock) disable iff (reset)
        !(marIn && memWrite))
        else $error("MAR load and memory write in the same cycle");

    // Only reset clears the halt state
    haltSticky: assert property (@(posedge clock) disable iff (reset)
        halted |=> halted)
        else $error("halted fell without reset");

    noRetireWhileHalted: assert property (@(posedge clock) disable iff (reset)
        halted |-> !instructionDone)
        else $error("instructionDone pulsed while halted");

endmodule

// File: cpuTop.sv
`timescale 1ns/100ps
`include "cpu_params.svh"

module cpuTop
    import cpuTypes_pkg::*;
(
    input  logic                              clock,
    input  logic                              reset,
    input  logic                              run,
    input  logic                              loadEnable,
    input  logic [`CPU_ADDR_WIDTH-1:0]        loadAddress,
    input  logic [`CPU_WIDTH-1:0]             loadData,
    input  logic [$clog2(`CPU_REG_COUNT)-1:0] debugSelect,
    output logic [`CPU_WIDTH-1:0]             debugValue,
    output logic                              halted,
    output logic                              instructionDone
);

    stepT   step;
    opcodeT opcode;
    opcodeT aluOp;
    logic   pcOut, zOut, mdrOut, regOut, cOut, baOut;
    logic   marIn, mdrIn, irIn, pcIn, yIn, zIn, rIn, incPc;
    logic   gra, grb, grc;
    logic   memRead, memWrite;
    logic   preloadEnable;

    logic [`CPU_WIDTH-1:0] bus;
    logic [`CPU_WIDTH-1:0] pc;
    logic [`CPU_WIDTH-1:0] ir;
    logic [`CPU_WIDTH-1:0] cValue;
    logic [`CPU_WIDTH-1:0] readValue;
    logic [`CPU_WIDTH-1:0] zValue;
    logic [`CPU_WIDTH-1:0] mdrValue;

    // Single bus reads zero when nothing drives it
    assign bus = ({`CPU_WIDTH{pcOut}} & pc)
               | ({`CPU_WIDTH{zOut}} & zValue)
               | ({`CPU_WIDTH{mdrOut}} & mdrValue)
               | ({`CPU_WIDTH{regOut | baOut}} & readValue)  // BAout also reads Rb
               | ({`CPU_WIDTH{cOut}} & cValue);

    assign cValue = {{(`CPU_WIDTH-19){ir[18]}}, ir[18:0]};  // Sign-extended C

    // Bypass while IR loads so the T3 strobes are set up during T2
    assign opcode = irIn ? opcodeT'(bus[31:27]) : opcodeT'(ir[31:27]);

    assign preloadEnable = loadEnable && (step == stepIdle);

    always_ff @(posedge clock) begin
        if (reset) begin
            pc <= '0;                  // Execution starts at address 0
            ir <= '0;
        end else begin
            if (pcIn) begin
                pc <= bus;
            end
            if (irIn) begin
                ir <= bus;
            end
        end
    end

    controlSequencer sequencer (
        .clock(clock), .reset(reset), .run(run), .opcode(opcode), .step(step),
        .pcOut(pcOut), .zOut(zOut), .mdrOut(mdrOut), .regOut(regOut),
        .cOut(cOut), .baOut(baOut), .marIn(marIn), .mdrIn(mdrIn), .irIn(irIn),
        .pcIn(pcIn), .yIn(yIn), .zIn(zIn), .rIn(rIn), .incPc(incPc),
        .gra(gra), .grb(grb), .grc(grc), .memRead(memRead), .memWrite(memWrite),
        .halted(halted), .instructionDone(instructionDone), .aluOp(aluOp)
    );

    registerFile registers (
        .clock(clock), .reset(reset), .rIn(rIn), .gra(gra), .grb(grb), .grc(grc),
        .baOut(baOut), .instruction(ir), .bus(bus), .readValue(readValue),
        .debugSelect(debugSelect), .debugValue(debugValue)
    );

    aluUnit alu (
        .clock(clock), .reset(reset), .yIn(yIn), .zIn(zIn), .incPc(incPc),
        .aluOp(aluOp), .bus(bus), .zValue(zValue)
    );

    memoryInterface memory (
        .clock(clock), .reset(reset), .marIn(marIn), .mdrIn(mdrIn),
        .memRead(memRead), .memWrite(memWrite), .loadEnable(preloadEnable),
        .bus(bus), .loadAddress(loadAddress), .loadData(loadData),
        .mdrValue(mdrValue)
    );

endmodule

// File: memoryInterface.sv
`timescale 1ns/100ps
`include "cpu_params.svh"

module memoryInterface (
    input  logic                       clock,
    input  logic                       reset,
    input  logic                       marIn,
    input  logic                       mdrIn,
    input  logic                       memRead,
    input  logic                       memWrite,
    input  logic                       loadEnable,
    input  logic [`CPU_WIDTH-1:0]      bus,
    input  logic [`CPU_ADDR_WIDTH-1:0] loadAddress,
    input  logic [`CPU_WIDTH-1:0]      loadData,
    output logic [`CPU_WIDTH-1:0]      mdrValue
);

    logic [`CPU_ADDR_WIDTH-1:0] mar;
    logic [`CPU_WIDTH-1:0]      ram [`CPU_MEM_DEPTH];

    always_ff @(posedge clock) begin
        if (reset) begin
            mar <= '0;
        end else if (marIn) begin
            mar <= bus[`CPU_ADDR_WIDTH-1:0];  // Upper address bits ignored
        end
    end

    // Synchronous read straight into the MDR
    always_ff @(posedge clock) begin
        if (mdrIn) begin
            if (memRead) begin
                mdrValue <= ram[mar];
            end else begin
                mdrValue <= bus;              // Store data from a register
            end
        end
    end

    // Preload is only enabled while the sequencer is idle
    always_ff @(posedge clock) begin
        if (memWrite) begin
            ram[mar] <= mdrValue;
        end else if (loadEnable) begin
            ram[loadAddress] <= loadData;
        end
    end

endmodule

// File: aluUnit.sv
`timescale 1ns/100ps
`include "cpu_params.svh"

module aluUnit
    import cpuTypes_pkg::*;
(
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  yIn,
    input  logic                  zIn,
    input  logic                  incPc,
    input  opcodeT                aluOp,
    input  logic [`CPU_WIDTH-1:0] bus,
    output logic [`CPU_WIDTH-1:0] zValue
);

    logic [`CPU_WIDTH-1:0] y;
    logic [`CPU_WIDTH-1:0] result;

    // Y holds the first operand, the bus the second
    always_comb begin
        if (incPc) begin
            result = bus + `CPU_WIDTH'(1);  // PC increment ignores Y
        end else begin
            case (aluOp)
                opSub:   result = y - bus;
                opAnd:   result = y & bus;
                opOr:    result = y | bus;
                default: result = y + bus;  // Add and all address forming
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            y      <= '0;
            zValue <= '0;
        end else begin
            if (yIn) begin
                y <= bus;
            end
            if (zIn) begin
                zValue <= result;
            end
        end
    end

endmodule

// File: registerFile.sv
`timescale 1ns/100ps
`include "cpu_params.svh"

module registerFile (
    input  logic                                 clock,
    input  logic                                 reset,
    input  logic                                 rIn,
    input  logic                                 gra,
    input  logic                                 grb,
    input  logic                                 grc,
    input  logic                                 baOut,
    input  logic [`CPU_WIDTH-1:0]                instruction,
    input  logic [`CPU_WIDTH-1:0]                bus,
    output logic [`CPU_WIDTH-1:0]                readValue,
    input  logic [$clog2(`CPU_REG_COUNT)-1:0]    debugSelect,
    output logic [`CPU_WIDTH-1:0]                debugValue
);

    logic [`CPU_WIDTH-1:0]             regs [`CPU_REG_COUNT];
    logic [$clog2(`CPU_REG_COUNT)-1:0] select;

    // Only one group select is active per step
    always_comb begin
        if (gra) begin
            select = instruction[26:23];  // Ra
        end else if (grb) begin
            select = instruction[22:19];  // Rb
        end else if (grc) begin
            select = instruction[18:15];  // Rc
        end else begin
            select = '0;
        end
    end

    // R0 reads as zero only for base addressing
    assign readValue  = (baOut && select == '0) ? '0 : regs[select];
    assign debugValue = regs[debugSelect];

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < `CPU_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (rIn) begin
            regs[select] <= bus;
        end
    end

endmodule

// File: controlSequencer.sv
`timescale 1ns/100ps
`include "cpu_params.svh"

module controlSequencer
    import cpuTypes_pkg::*;
(
    input  logic   clock,
    input  logic   reset,
    input  logic   run,
    input  opcodeT opcode,
    output stepT   step,
    output logic   pcOut, zOut, mdrOut, regOut, cOut, baOut,
    output logic   marIn, mdrIn, irIn, pcIn, yIn, zIn, rIn, incPc,
    output logic   gra, grb, grc,
    output logic   memRead, memWrite,
    output logic   halted, instructionDone,
    output opcodeT aluOp
);

    // Field order matches the output concatenation below
    typedef struct packed {
        logic pcOut, zOut, mdrOut, regOut, cOut, baOut;      // Bus sources
        logic marIn, mdrIn, irIn, pcIn, yIn, zIn, rIn, incPc; // Register loads
        logic gra, grb, grc;                                  // Register group selects
        logic memRead, memWrite;
        logic halted, instructionDone;
    } strobeT;

    stepT   stepNext;
    strobeT strobeNext;
    strobeT strobeReg;
    opcodeT aluOpNext;
    logic   isLong;
    logic   isAluReg;
    logic   useBase;
    logic   isValid;

    assign isLong   = opcode inside {opLd, opSt};             // Memory access after Z
    assign isAluReg = opcode inside {opAdd, opSub, opAnd, opOr};
    assign useBase  = opcode inside {opLd, opLdi, opSt};      // R0 reads zero
    assign isValid  = opcode inside {opLd, opLdi, opSt, opAdd, opSub, opAnd, opOr, opAddi};

    always_comb begin
        case (step)
            stepIdle: stepNext = run ? stepT0 : stepIdle;
            stepT0:   stepNext = stepT1;
            stepT1:   stepNext = stepT2;
            stepT2:   stepNext = isValid ? stepT3 : stepHalt;  // Opcode still on the bus
            stepT3:   stepNext = stepT4;
            stepT4:   stepNext = stepT5;
            stepT5:   stepNext = isLong ? stepT6 : stepT0;
            stepT6:   stepNext = stepT7;
            stepT7:   stepNext = stepT0;
            stepHalt: stepNext = stepHalt;                     // Only reset leaves
            default:  stepNext = stepIdle;
        endcase
    end

    // Strobes for the step being entered, registered on the same edge
    always_comb begin
        strobeNext = '0;
        aluOpNext  = opAdd;
        case (stepNext)
            stepT0: begin
                strobeNext.pcOut = 1'b1;
                strobeNext.marIn = 1'b1;
                strobeNext.incPc = 1'b1;
                strobeNext.zIn   = 1'b1;     // Z takes PC + 1
            end
            stepT1: begin
                strobeNext.zOut    = 1'b1;
                strobeNext.pcIn    = 1'b1;
                strobeNext.memRead = 1'b1;
                strobeNext.mdrIn   = 1'b1;
            end
            stepT2: begin
                strobeNext.mdrOut = 1'b1;
                strobeNext.irIn   = 1'b1;
            end
            stepT3: begin
                strobeNext.grb    = 1'b1;
                strobeNext.yIn    = 1'b1;
                strobeNext.baOut  = useBase;
                strobeNext.regOut = !useBase;
            end
            stepT4: begin
                strobeNext.zIn = 1'b1;
                if (isAluReg) begin
                    strobeNext.grc    = 1'b1;
                    strobeNext.regOut = 1'b1;
                    aluOpNext         = opcode;
                end else begin
                    strobeNext.cOut = 1'b1;  // Base plus offset
                end
            end
            stepT5: begin
                strobeNext.zOut = 1'b1;
                if (isLong) begin
                    strobeNext.marIn = 1'b1;
                end else begin
                    strobeNext.gra             = 1'b1;
                    strobeNext.rIn             = 1'b1;
                    strobeNext.instructionDone = 1'b1;
                end
            end
            stepT6: begin
                strobeNext.mdrIn = 1'b1;
                if (opcode == opSt) begin
                    strobeNext.gra    = 1'b1;
                    strobeNext.regOut = 1'b1;  // Ra into MDR
                end else begin
                    strobeNext.memRead = 1'b1;
                end
            end
            stepT7: begin
                strobeNext.instructionDone = 1'b1;
                if (opcode == opSt) begin
                    strobeNext.memWrite = 1'b1;
                end else begin
                    strobeNext.mdrOut = 1'b1;
                    strobeNext.gra    = 1'b1;
                    strobeNext.rIn    = 1'b1;
                end
            end
            stepHalt: strobeNext.halted = 1'b1;
            default:  strobeNext = '0;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            step      <= stepIdle;
            strobeReg <= '0;
            aluOp     <= opAdd;
        end else begin
            step      <= stepNext;
            strobeReg <= strobeNext;
            aluOp     <= aluOpNext;
        end
    end

    assign {pcOut, zOut, mdrOut, regOut, cOut, baOut,
            marIn, mdrIn, irIn, pcIn, yIn, zIn, rIn, incPc,
            gra, grb, grc,
            memRead, memWrite,
            halted, instructionDone} = strobeReg;

endmodule

// File: cpuTypes_pkg.sv
package cpuTypes_pkg;

    // Opcode field, IR bits 31..27
    typedef enum logic [4:0] {
        opLd   = 5'd0,  // Ra = mem[Rb + C]
        opLdi  = 5'd1,  // Ra = Rb + C
        opSt   = 5'd2,  // mem[Rb + C] = Ra
        opAdd  = 5'd3,
        opSub  = 5'd4,
        opAnd  = 5'd5,
        opOr   = 5'd6,
        opAddi = 5'd7,  // Like ldi but R0 is a real operand
        opHalt = 5'd8
    } opcodeT;

    // One step per clock with T0..T2 as the fetch
    typedef enum logic [3:0] {
        stepIdle = 4'd0,
        stepT0   = 4'd1,
        stepT1   = 4'd2,
        stepT2   = 4'd3,
        stepT3   = 4'd4,
        stepT4   = 4'd5,
        stepT5   = 4'd6,
        stepT6   = 4'd7,
        stepT7   = 4'd8,
        stepHalt = 4'd9
    } stepT;

endpackage

// File: cpu_params.svh
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// Fixed by the 32-bit instruction format

`define CPU_WIDTH      32   // Data path and bus width

`define CPU_ADDR_WIDTH 9    // Word address into the RAM

`define CPU_MEM_DEPTH  512  // Words of RAM

// Sixteen registers, so each register field in the IR is 4 bits wide
`define CPU_REG_COUNT  16

`endif
